// File: armStatusPkg.sv
`default_nettype none

package armStatusPkg;

  // Mode field encodings, CPSR bits 4:0
  typedef enum logic [4:0] {
    modeUsr = 5'b10000,
    modeFiq = 5'b10001,
    modeIrq = 5'b10010,
    modeSvc = 5'b10011,
    modeAbt = 5'b10111,
    modeUnd = 5'b11011,
    modeSys = 5'b11111
  } cpuMode;

  // Index into the saved status register bank
  typedef enum logic [2:0] {
    bankSvc = 3'd0,
    bankAbt = 3'd1,
    bankUnd = 3'd2,
    bankIrq = 3'd3,
    bankFiq = 3'd4
  } spsrBank;

  localparam int NumBanks = 5;                    // One SPSR per privileged exception mode

  localparam logic [31:0] ResetCpsr = 32'h0000_00D3; // Supervisor, I and F set

  // Interrupt disable bits inside the CPSR
  localparam int CpsrIBit = 7;
  localparam int CpsrFBit = 6;

  // Bit positions in the Exceptions request vector
  localparam int excFiq         = 0;
  localparam int excIrq         = 1;
  localparam int excDataAbt     = 2;
  localparam int excPrefetchAbt = 3;
  localparam int excSwi         = 4;
  localparam int excUndef       = 5;

endpackage

`default_nettype wire

// File: exceptionPrioritizer.sv
`default_nettype none

module exceptionPrioritizer import armStatusPkg::*; #(
  parameter bit HighVectors = 1'b0  // 1 puts the vector table at 0xFFFF0000
) (
  input  logic [5:0]  Exceptions,
  input  logic [31:0] cpsr,
  output logic        takeException,
  output cpuMode      targetMode,
  output spsrBank     targetBank,
  output logic [31:0] VectorAddr
);

  cpuMode      curMode;
  logic        fiqReq, irqReq;      // Interrupts after I/F masking
  logic        dataAbtReq, prefetchAbtReq, undefReq, swiReq;
  logic [7:0]  vecOffset;
  logic [31:0] vecBase;

  assign curMode = cpuMode'(cpsr[4:0]);

  // A request that would re-enter the current mode is dropped,
  // which lets the next one down the chain win
  assign fiqReq         = Exceptions[excFiq] & ~cpsr[CpsrFBit] & (curMode != modeFiq);
  assign irqReq         = Exceptions[excIrq] & ~cpsr[CpsrIBit] & (curMode != modeIrq);
  assign dataAbtReq     = Exceptions[excDataAbt] & (curMode != modeAbt);
  assign prefetchAbtReq = Exceptions[excPrefetchAbt] & (curMode != modeAbt);
  assign undefReq       = Exceptions[excUndef] & (curMode != modeUnd);
  assign swiReq         = Exceptions[excSwi] & (curMode != modeSvc);

  // Fixed priority chain
  always_comb begin
    takeException = 1'b1;
    targetMode    = modeSvc;
    targetBank    = bankSvc;
    vecOffset     = 8'h00;     // Reset vector when nothing is taken
    if (dataAbtReq) begin
      targetMode = modeAbt;
      targetBank = bankAbt;
      vecOffset  = 8'h10;
    end else if (fiqReq) begin
      targetMode = modeFiq;
      targetBank = bankFiq;
      vecOffset  = 8'h1C;
    end else if (irqReq) begin
      targetMode = modeIrq;
      targetBank = bankIrq;
      vecOffset  = 8'h18;
    end else if (prefetchAbtReq) begin
      targetMode = modeAbt;    // Shares abort mode and bank with data abort
      targetBank = bankAbt;
      vecOffset  = 8'h0C;
    end else if (undefReq) begin
      targetMode = modeUnd;
      targetBank = bankUnd;
      vecOffset  = 8'h04;
    end else if (swiReq) begin
      vecOffset  = 8'h08;      // Supervisor target, defaults already set
    end else begin
      takeException = 1'b0;
    end
  end

  assign vecBase    = HighVectors ? 32'hFFFF_0000 : 32'h0000_0000;
  assign VectorAddr = vecBase | {24'h0, vecOffset}; // Offsets sit below the base

endmodule

`default_nettype wire

// File: msrMerge.sv
`default_nettype none

module msrMerge import armStatusPkg::*; (
  input  logic [4:0]  MsrMask,     // [4] SPSR target, [3:0] f, s, x, c byte enables
  input  logic [31:0] AluOut,
  input  logic [31:0] cpsr,
  input  logic [31:0] currentSpsr,
  output logic [31:0] msrValue,
  output logic        msrWrite
);

  cpuMode      curMode;
  logic        privileged;   // Anything but user
  logic        hasSpsr;      // Neither user nor system
  logic        toSpsr;
  logic        allowed;
  logic        legalMode;    // AluOut[4:0] is a real mode
  logic [3:0]  byteEn;       // Byte enables after privilege check
  logic [31:0] target;       // Word being modified

  assign curMode    = cpuMode'(cpsr[4:0]);
  assign privileged = (curMode != modeUsr);
  assign hasSpsr    = privileged & (curMode != modeSys);
  assign toSpsr     = MsrMask[4];

  // SPSR writes need a banked SPSR to land in
  assign allowed = toSpsr ? hasSpsr : 1'b1;

  assign target = toSpsr ? currentSpsr : cpsr;

  // Flags byte is open in every mode
  assign byteEn[3]   = MsrMask[3];
  assign byteEn[2:0] = MsrMask[2:0] & {3{privileged}};

  // Mode legality of the incoming value
  always_comb begin
    case (cpuMode'(AluOut[4:0]))
      modeUsr, modeFiq, modeIrq, modeSvc,
      modeAbt, modeUnd, modeSys: legalMode = 1'b1;
      default:                   legalMode = 1'b0;
    endcase
  end

  always_comb begin
    // Control byte, mode field guarded separately
    if (byteEn[0]) begin
      msrValue[7:5] = AluOut[7:5];
      msrValue[4:0] = legalMode ? AluOut[4:0] : target[4:0]; // Bad mode keeps old one
    end else begin
      msrValue[7:0] = target[7:0];
    end
    // Extension, status and flags bytes
    for (int i = 1; i < 4; i++) begin
      msrValue[i*8 +: 8] = byteEn[i] ? AluOut[i*8 +: 8] : target[i*8 +: 8];
    end
  end

  // Any raw enable marks an MSR, even if privilege blocks every byte
  assign msrWrite = allowed & (|MsrMask[3:0]);

endmodule

`default_nettype wire

// File: statusRegs.sv
`default_nettype none

module statusRegs import armStatusPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        NotStallW,
  input  logic        takeException,
  input  cpuMode      targetMode,
  input  spsrBank     targetBank,
  input  logic        msrWrite,
  input  logic [31:0] msrValue,
  input  logic [4:0]  MsrMask,
  input  logic        RestoreCpsr,
  input  logic [3:0]  FlagsNext,
  input  logic        CoProcFlagUpd,
  input  logic [31:0] AluOut,
  output logic [31:0] cpsr,
  output logic [31:0] currentSpsr
);

  logic [31:0] spsr [NumBanks];  // Saved status, indexed by spsrBank
  cpuMode      curMode;
  spsrBank     curBank;          // Bank of the current mode
  logic        curHasSpsr;       // Low in user and system mode
  logic [3:0]  flagsUpdate;
  logic [31:0] excCpsr;          // CPSR on exception entry

  assign curMode = cpuMode'(cpsr[4:0]);

  // Bank decode from current mode
  always_comb begin
    curHasSpsr = 1'b1;
    curBank    = bankSvc;
    case (curMode)
      modeSvc: curBank = bankSvc;
      modeAbt: curBank = bankAbt;
      modeUnd: curBank = bankUnd;
      modeIrq: curBank = bankIrq;
      modeFiq: curBank = bankFiq;
      default: curHasSpsr = 1'b0;    // User, system or junk
    endcase
  end

  // Without a banked SPSR the CPSR is shown instead
  assign currentSpsr = curHasSpsr ? spsr[curBank] : cpsr;

  // Coprocessor transfers bring flags in on AluOut
  assign flagsUpdate = CoProcFlagUpd ? AluOut[31:28] : FlagsNext;

  // Exception entry: keep upper bits and T, force I, F only for FIQ
  always_comb begin
    excCpsr           = cpsr;
    excCpsr[4:0]      = targetMode;
    excCpsr[CpsrIBit] = 1'b1;
    if (targetMode == modeFiq) begin
      excCpsr[CpsrFBit] = 1'b1;
    end
  end

  // Falling-edge update, same edge as the rest of writeback
  always_ff @(negedge clk) begin
    if (reset) begin
      cpsr <= ResetCpsr;
      for (int b = 0; b < NumBanks; b++) begin
        spsr[b] <= '0;
      end
    end else if (NotStallW) begin
      if (takeException) begin
        spsr[targetBank] <= cpsr;       // Save old status first
        cpsr             <= excCpsr;
      end else if (msrWrite) begin
        if (MsrMask[4]) begin
          spsr[curBank] <= msrValue;    // msrMerge only allows this with a bank
        end else begin
          cpsr <= msrValue;
        end
      end else if (RestoreCpsr) begin
        if (curHasSpsr) begin
          cpsr <= spsr[curBank];
        end                             // No SPSR, nothing happens
      end else begin
        cpsr <= {flagsUpdate, cpsr[27:0]};
      end
    end
  end

endmodule

`default_nettype wire

// File: armStatusUnit.sv
`default_nettype none

module armStatusUnit import armStatusPkg::*; #(
  parameter bit HighVectors = 1'b0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        NotStallW,
  input  logic [5:0]  Exceptions,     // Level requests, see excFiq..excUndef
  input  logic [4:0]  MsrMask,
  input  logic [31:0] AluOut,
  input  logic [3:0]  FlagsNext,      // From the condition unit
  input  logic        CoProcFlagUpd,
  input  logic        RestoreCpsr,
  output logic [31:0] CpsrData,
  output logic [31:0] SpsrData,
  output logic        ExceptionTaken,
  output logic [31:0] VectorAddr      // To fetch
);

  cpuMode      targetMode;
  spsrBank     targetBank;
  logic [31:0] msrValue;
  logic        msrWrite;

  // Exception choice, combinational
  exceptionPrioritizer #(
    .HighVectors(HighVectors)
  ) uPrio (
    .Exceptions   (Exceptions),
    .cpsr         (CpsrData),
    .takeException(ExceptionTaken),
    .targetMode   (targetMode),
    .targetBank   (targetBank),
    .VectorAddr   (VectorAddr)
  );

  // MSR word builder
  msrMerge uMsr (
    .MsrMask    (MsrMask),
    .AluOut     (AluOut),
    .cpsr       (CpsrData),
    .currentSpsr(SpsrData),
    .msrValue   (msrValue),
    .msrWrite   (msrWrite)
  );

  statusRegs uRegs (
    .clk          (clk),
    .reset        (reset),
    .NotStallW    (NotStallW),
    .takeException(ExceptionTaken),
    .targetMode   (targetMode),
    .targetBank   (targetBank),
    .msrWrite     (msrWrite),
    .msrValue     (msrValue),
    .MsrMask      (MsrMask),
    .RestoreCpsr  (RestoreCpsr),
    .FlagsNext    (FlagsNext),
    .CoProcFlagUpd(CoProcFlagUpd),
    .AluOut       (AluOut),
    .cpsr         (CpsrData),
    .currentSpsr  (SpsrData)
  );

endmodule

`default_nettype wire

// File: armStatusUnit_chk.sv
`default_nettype none

module armStatusUnit_chk import armStatusPkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        NotStallW,
  input logic [31:0] cpsr,
  input logic [31:0] spsr [NumBanks]
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [NumBanks*32-1:0] spsrFlat;   // Whole bank as one vector

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      spsrFlat[b*32 +: 32] = spsr[b];
    end
  end

  // Only the seven architected modes
  modeLegal: assert property (@(negedge clk) disable iff (reset)
    cpsr[4:0] inside {modeUsr, modeFiq, modeIrq, modeSvc, modeAbt, modeUnd, modeSys})
    else $error("CPSR mode field 0x%02h is not a legal mode", cpsr[4:0]);

  resetValue: assert property (@(negedge clk) reset |=> (cpsr == ResetCpsr))
    else $error("CPSR is 0x%08h after reset", cpsr);

  // Stall freezes both CPSR and the bank
  stallHold: assert property (@(negedge clk) disable iff (reset)
    !NotStallW |=> ($stable(cpsr) && $stable(spsrFlat)))
    else $error("Status registers changed during stall");

endmodule

bind statusRegs armStatusUnit_chk uChk (
  .clk      (clk),
  .reset    (reset),
  .NotStallW(NotStallW),
  .cpsr     (cpsr),
  .spsr     (spsr)
);

`default_nettype wire

// File: armStatusUnit_tb.sv
`default_nettype none

module armStatusUnit_tb import armStatusPkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod   = 10;
  localparam int ResetCycles = 10;

  // Request masks for the Exceptions vector
  localparam logic [5:0] ReqNone        = 6'b000000;
  localparam logic [5:0] ReqFiq         = 6'(1 << excFiq);
  localparam logic [5:0] ReqIrq         = 6'(1 << excIrq);
  localparam logic [5:0] ReqDataAbt     = 6'(1 << excDataAbt);
  localparam logic [5:0] ReqPrefetchAbt = 6'(1 << excPrefetchAbt);
  localparam logic [5:0] ReqSwi         = 6'(1 << excSwi);
  localparam logic [5:0] ReqUndef       = 6'(1 << excUndef);
  localparam logic [5:0] ReqAll         = 6'b111111;

  // One table row, stimulus first, then expected responses
  typedef struct packed {
    logic [5:0]  exc;
    logic [4:0]  mask;
    logic [31:0] alu;
    logic [3:0]  flags;
    logic        coProc;
    logic        restore;
    logic        notStall;
    logic        expTaken;
    logic [31:0] expVec;
    logic [31:0] expCpsr;
    logic [31:0] expSpsr;
  } testStep;

  logic        clk;
  logic        reset;
  logic        NotStallW;
  logic [5:0]  Exceptions;
  logic [4:0]  MsrMask;
  logic [31:0] AluOut;
  logic [3:0]  FlagsNext;
  logic        CoProcFlagUpd;
  logic        RestoreCpsr;
  logic [31:0] CpsrData;
  logic [31:0] SpsrData;
  logic        ExceptionTaken;
  logic [31:0] VectorAddr;

  testStep steps[$];
  bit      tableLoaded = 1'b0;
  int      errCount    = 0;
  int      curStep     = -1;   // -1 while checking reset state

  armStatusUnit #(
    .HighVectors(1'b0)
  ) UUT (
    .clk           (clk),
    .reset         (reset),
    .NotStallW     (NotStallW),
    .Exceptions    (Exceptions),
    .MsrMask       (MsrMask),
    .AluOut        (AluOut),
    .FlagsNext     (FlagsNext),
    .CoProcFlagUpd (CoProcFlagUpd),
    .RestoreCpsr   (RestoreCpsr),
    .CpsrData      (CpsrData),
    .SpsrData      (SpsrData),
    .ExceptionTaken(ExceptionTaken),
    .VectorAddr    (VectorAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      errCount++;
      $display("CHECK FAILED at %0t ns: step %0d, %s is 0x%08h, expected 0x%08h",
               $time, curStep, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  task automatic addStep(input logic [5:0] exc, input logic [4:0] mask,
                         input logic [31:0] alu, input logic [3:0] flags,
                         input logic coProc, input logic restore, input logic notStall,
                         input logic expTaken, input logic [31:0] expVec,
                         input logic [31:0] expCpsr, input logic [31:0] expSpsr);
    testStep s;
    s = {exc, mask, alu, flags, coProc, restore, notStall, expTaken, expVec, expCpsr, expSpsr};
    steps.push_back(s);
  endtask

  // Expected values worked out by hand, state carries from row to row
  task automatic loadTable();
    addStep(ReqNone, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,          // Idle after reset
            1'b0, 32'h00, 32'h000000D3, 32'h00000000);
    addStep(ReqFiq | ReqIrq, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,  // Masked by I and F
            1'b0, 32'h00, 32'h000000D3, 32'h00000000);
    addStep(ReqNone, 5'b01111, 32'h20000010, 4'h0, 1'b0, 1'b0, 1'b1,   // Svc to usr
            1'b0, 32'h00, 32'h20000010, 32'h20000010);
    addStep(ReqNone, 5'b01001, 32'h900000D3, 4'h0, 1'b0, 1'b0, 1'b1,   // Usr, flags only
            1'b0, 32'h00, 32'h90000010, 32'h90000010);
    addStep(ReqAll, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,           // Data abort wins
            1'b1, 32'h10, 32'h90000097, 32'h90000010);
    addStep(ReqDataAbt | ReqPrefetchAbt, 5'b00000, 32'h0, 4'h9, 1'b0, 1'b0, 1'b1,
            1'b0, 32'h00, 32'h90000097, 32'h90000010);             // Already in abort
    addStep(ReqNone, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1,          // Restore from abt
            1'b0, 32'h00, 32'h90000010, 32'h90000010);
    addStep(ReqSwi, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,           // SWI into svc
            1'b1, 32'h08, 32'h90000093, 32'h90000010);
    addStep(ReqNone, 5'b11001, 32'h400000C5, 4'h0, 1'b0, 1'b0, 1'b1,   // SPSR, bad mode
            1'b0, 32'h00, 32'h90000093, 32'h400000D0);
    addStep(ReqNone, 5'b00001, 32'h000000DF, 4'h0, 1'b0, 1'b0, 1'b1,   // Svc to sys
            1'b0, 32'h00, 32'h900000DF, 32'h900000DF);
    addStep(ReqNone, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1,          // Restore in sys
            1'b0, 32'h00, 32'h900000DF, 32'h900000DF);
    addStep(ReqNone, 5'b00000, 32'h0, 4'h6, 1'b0, 1'b0, 1'b1,          // Condition flags
            1'b0, 32'h00, 32'h600000DF, 32'h600000DF);
    addStep(ReqNone, 5'b00000, 32'hA0000000, 4'h6, 1'b1, 1'b0, 1'b1,   // Coprocessor flags
            1'b0, 32'h00, 32'hA00000DF, 32'hA00000DF);
    addStep(ReqUndef, 5'b00000, 32'h0, 4'h1, 1'b0, 1'b0, 1'b0,         // Stalled
            1'b1, 32'h04, 32'hA00000DF, 32'hA00000DF);
    addStep(ReqNone, 5'b00000, 32'h0, 4'hA, 1'b0, 1'b0, 1'b1,
            1'b0, 32'h00, 32'hA00000DF, 32'hA00000DF);
    addStep(ReqNone, 5'b11111, 32'h12345613, 4'h5, 1'b0, 1'b0, 1'b1,   // No SPSR in sys
            1'b0, 32'h00, 32'h500000DF, 32'h500000DF);
    addStep(ReqIrq, 5'b00000, 32'h0, 4'hA, 1'b0, 1'b0, 1'b1,           // I still set
            1'b0, 32'h00, 32'hA00000DF, 32'hA00000DF);
    addStep(ReqUndef, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,
            1'b1, 32'h04, 32'hA00000DB, 32'hA00000DF);
    addStep(ReqNone, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b1, 1'b1,          // Back to sys
            1'b0, 32'h00, 32'hA00000DF, 32'hA00000DF);
    addStep(ReqNone, 5'b00001, 32'h0000001F, 4'h0, 1'b0, 1'b0, 1'b1,   // Clear I and F
            1'b0, 32'h00, 32'hA000001F, 32'hA000001F);
    addStep(ReqFiq | ReqIrq, 5'b00000, 32'h0, 4'h0, 1'b0, 1'b0, 1'b1,  // FIQ over IRQ
            1'b1, 32'h1C, 32'hA00000D1, 32'hA000001F);
  endtask

  initial begin
    reset         = 1'b1;
    NotStallW     = 1'b1;
    Exceptions    = '0;
    MsrMask       = '0;
    AluOut        = '0;
    FlagsNext     = '0;
    CoProcFlagUpd = 1'b0;
    RestoreCpsr   = 1'b0;
    loadTable();
    tableLoaded = 1'b1;

    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
    checkValue(CpsrData, 32'h000000D3, "CpsrData after reset");

    for (int i = 0; i < steps.size(); i++) begin
      curStep = i;
      Exceptions    <= steps[i].exc;
      MsrMask       <= steps[i].mask;
      AluOut        <= steps[i].alu;
      FlagsNext     <= steps[i].flags;
      CoProcFlagUpd <= steps[i].coProc;
      RestoreCpsr   <= steps[i].restore;
      NotStallW     <= steps[i].notStall;
      #(ClkPeriod / 2 - 1);   // Just ahead of the falling edge
      checkValue({31'b0, ExceptionTaken}, {31'b0, steps[i].expTaken}, "ExceptionTaken");
      checkValue(VectorAddr, steps[i].expVec, "VectorAddr");
      @(posedge clk);          // Register update is now visible
      checkValue(CpsrData, steps[i].expCpsr, "CpsrData");
      checkValue(SpsrData, steps[i].expSpsr, "SpsrData");
    end

    if (errCount == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "%0d checks did not match", errCount);
    end
  end

  // Reset plus one cycle per row, with some slack
  initial begin : watchdog
    wait (tableLoaded);
    #((ResetCycles + steps.size() + 10) * ClkPeriod);
    $display("Watchdog expired: the test table did not finish in time");
    $display("TB FAILED");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// File: compile.f
armStatusPkg.sv
exceptionPrioritizer.sv
msrMerge.sv
statusRegs.sv
armStatusUnit.sv
armStatusUnit_chk.sv
armStatusUnit_tb.sv

// File: Makefile
# Verilator flow for the program status unit

VERILATOR  ?= verilator
TOP        ?= armStatusUnit_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
EXTRA_ARGS ?=
PASS_MSG   ?= TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_ARGS)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
